// ==== design/cfg_pkg.sv ====
package cfg_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int data_w    = 32;
    localparam int addr_w    = 64;
    localparam int offset_w  = 16;

    // Record layout below is built around exactly eight setup words
    localparam int seq_words = 8;

    // ----------------------------------------------------------------------
    // Response buffer classes
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        buf_none         = 2'd0,
        buf_cu_setup     = 2'd1,
        buf_engine_setup = 2'd2,
        buf_data         = 2'd3
    } buffer_class_t;

    // One memory response word
    typedef struct packed {
        logic                valid;
        buffer_class_t       buffer_class;
        logic [offset_w-1:0] offset;
        logic [data_w-1:0]   data;
    } mem_word_t;

    // ----------------------------------------------------------------------
    // Engine configuration record
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic mode_counter;
        logic mode_buffer;
        logic mode_sequence;
        logic decrement;
        logic increment;
    } cfg_flags_t;

    typedef struct packed {
        cfg_flags_t          flags;
        logic [data_w-1:0]   index_start;
        logic [data_w-1:0]   index_end;
        logic [data_w-1:0]   stride;
        logic [data_w-2:0]   granularity;
        logic                direction;
        logic [addr_w-1:0]   array_pointer;
        logic [data_w-1:0]   array_size;
    } engine_config_t;

    // FIFO levels and read strobe
    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
        logic valid;
    } fifo_status_t;

endpackage : cfg_pkg

// ==== design/response_filter.sv ====
`timescale 1ns/1ns

module response_filter #(
    parameter int unsigned engine_slot = 0
) (
    input  logic              ap_clk,
    input  logic              arst_n,
    input  cfg_pkg::mem_word_t resp_in,
    output logic              push,
    output cfg_pkg::mem_word_t word
);

    // ----------------------------------------------------------------------
    // Offset window of this engine
    // ----------------------------------------------------------------------
    localparam logic [cfg_pkg::offset_w-1:0] win_lo =
        cfg_pkg::offset_w'(engine_slot * cfg_pkg::seq_words);
    localparam logic [cfg_pkg::offset_w-1:0] win_hi =
        cfg_pkg::offset_w'((engine_slot + 1) * cfg_pkg::seq_words);

    logic valid_q;
    logic class_ok;
    logic window_ok;

    // Strobe state
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_in.valid;
        end
    end

    // Word contents, qualified by valid_q
    always_ff @(posedge ap_clk) begin
        word <= resp_in;
    end

    // Only setup traffic is of interest
    assign class_ok = (word.buffer_class == cfg_pkg::buf_cu_setup) ||
                      (word.buffer_class == cfg_pkg::buf_engine_setup);

    assign window_ok = (word.offset >= win_lo) && (word.offset < win_hi);

    assign push = valid_q && class_ok && window_ok;

    // A push always traces back to a setup word seen at the input
    a_push_setup_only : assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        push |-> ($past(resp_in.buffer_class) == cfg_pkg::buf_cu_setup) ||
                 ($past(resp_in.buffer_class) == cfg_pkg::buf_engine_setup)
    );

endmodule : response_filter

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t   = logic,
    parameter int  depth       = 16,
    parameter int  prog_thresh = 8
) (
    input  logic                  ap_clk,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  payload_t              din,
    input  logic                  rd_en,
    output payload_t              dout,
    output cfg_pkg::fifo_status_t status
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             valid_q;
    logic             full;
    logic             empty;
    logic             wr_acc;
    logic             rd_acc;

    assign full   = (count == cnt_w'(depth));
    assign empty  = (count == '0);

    // Requests that hit a full or empty buffer are dropped
    assign wr_acc = wr_en && !full;
    assign rd_acc = rd_en && !empty;

    // ----------------------------------------------------------------------
    // Pointers and level
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_acc;
            if (wr_acc) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_acc) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_acc, rd_acc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Storage and registered read port
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_acc) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd_acc) begin
            dout <= mem[rd_ptr];
        end
    end

    always_comb begin
        status.full      = full;
        status.empty     = empty;
        status.prog_full = (count >= cnt_w'(prog_thresh));
        status.valid     = valid_q;
    end

    // The writer is expected to watch prog_full and hold off in time
    a_no_write_full : assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        wr_en |-> !full
    );

endmodule : sync_fifo

// ==== design/config_assembler.sv ====
`timescale 1ns/1ns

module config_assembler #(
    parameter int unsigned engine_slot = 0
) (
    input  logic                    ap_clk,
    input  logic                    arst_n,
    input  cfg_pkg::mem_word_t      word,
    input  cfg_pkg::fifo_status_t   word_status,
    output logic                    word_pop,
    input  cfg_pkg::fifo_status_t   record_status,
    output logic                    record_push,
    output cfg_pkg::engine_config_t record
);

    localparam logic [cfg_pkg::offset_w-1:0] win_lo =
        cfg_pkg::offset_w'(engine_slot * cfg_pkg::seq_words);

    logic                          assembling;
    logic [cfg_pkg::seq_words-1:0] idx;
    logic                          start;
    logic                          take;

    // ----------------------------------------------------------------------
    // Pop side
    // ----------------------------------------------------------------------
    // Hold off while the record buffer fills or a record is going out
    assign word_pop = !word_status.empty && !record_status.prog_full && !record_push;

    // A new record only begins on the first word of the window
    assign start = (word.offset == win_lo);
    assign take  = word_status.valid && (assembling || start);

    // ----------------------------------------------------------------------
    // Sequence tracking
    // ----------------------------------------------------------------------
    // idx is one-hot and sits on bit 0 while idle
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            assembling  <= 1'b0;
            idx         <= cfg_pkg::seq_words'(1);
            record_push <= 1'b0;
        end else begin
            record_push <= 1'b0;
            if (take) begin
                if (idx[cfg_pkg::seq_words-1]) begin
                    assembling  <= 1'b0;
                    idx         <= cfg_pkg::seq_words'(1);
                    record_push <= 1'b1;
                end else begin
                    assembling <= 1'b1;
                    idx        <= idx << 1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Record fields
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (take) begin
            unique case (1'b1)
                idx[0]: begin
                    record.flags.increment     <= word.data[0];
                    record.flags.decrement     <= word.data[1];
                    record.flags.mode_sequence <= word.data[2];
                    record.flags.mode_buffer   <= word.data[3];
                    record.flags.mode_counter  <= word.data[4];
                end
                idx[1]: record.index_start <= word.data;
                idx[2]: record.index_end   <= word.data;
                idx[3]: record.stride      <= word.data;
                idx[4]: begin
                    record.granularity <= word.data[cfg_pkg::data_w-2:0];
                    record.direction   <= word.data[cfg_pkg::data_w-1];
                end
                // Pointer arrives low half first
                idx[5]: record.array_pointer[cfg_pkg::data_w-1:0] <= word.data;
                idx[6]: begin
                    record.array_pointer[cfg_pkg::addr_w-1:cfg_pkg::data_w] <= word.data;
                end
                idx[7]: record.array_size <= word.data;
            endcase
        end
    end

    // prog_full gating on pops must leave room for every record
    a_no_push_full : assert property (
        @(posedge ap_clk) disable iff (!arst_n)
        record_push |-> !record_status.full
    );

endmodule : config_assembler

// ==== design/engine_config_loader.sv ====
`timescale 1ns/1ns

module engine_config_loader #(
    parameter int unsigned engine_slot = 0,
    parameter int          fifo_depth  = 16,
    parameter int          prog_thresh = 8
) (
    input  logic                    ap_clk,
    input  logic                    arst_n,
    input  cfg_pkg::mem_word_t      resp_in,
    output logic                    resp_prog_full,
    input  logic                    config_take,
    output logic                    config_valid,
    output cfg_pkg::engine_config_t config_out
);

    logic                    word_push;
    cfg_pkg::mem_word_t      word_din;
    cfg_pkg::mem_word_t      word_dout;
    cfg_pkg::fifo_status_t   word_status;
    logic                    word_pop;
    logic                    record_push;
    cfg_pkg::engine_config_t record_din;
    cfg_pkg::fifo_status_t   record_status;

    // ----------------------------------------------------------------------
    // Response side
    // ----------------------------------------------------------------------
    response_filter #(
        .engine_slot (engine_slot)
    ) filter0 (
        .ap_clk  (ap_clk),
        .arst_n  (arst_n),
        .resp_in (resp_in),
        .push    (word_push),
        .word    (word_din)
    );

    sync_fifo #(
        .payload_t   (cfg_pkg::mem_word_t),
        .depth       (fifo_depth),
        .prog_thresh (prog_thresh)
    ) word_fifo (
        .ap_clk (ap_clk),
        .arst_n (arst_n),
        .wr_en  (word_push),
        .din    (word_din),
        .rd_en  (word_pop),
        .dout   (word_dout),
        .status (word_status)
    );

    // ----------------------------------------------------------------------
    // Record side
    // ----------------------------------------------------------------------
    config_assembler #(
        .engine_slot (engine_slot)
    ) assembler0 (
        .ap_clk        (ap_clk),
        .arst_n        (arst_n),
        .word          (word_dout),
        .word_status   (word_status),
        .word_pop      (word_pop),
        .record_status (record_status),
        .record_push   (record_push),
        .record        (record_din)
    );

    sync_fifo #(
        .payload_t   (cfg_pkg::engine_config_t),
        .depth       (fifo_depth),
        .prog_thresh (prog_thresh)
    ) record_fifo (
        .ap_clk (ap_clk),
        .arst_n (arst_n),
        .wr_en  (record_push),
        .din    (record_din),
        .rd_en  (config_take),
        .dout   (config_out),
        .status (record_status)
    );

    assign resp_prog_full = word_status.prog_full;
    assign config_valid   = record_status.valid;

endmodule : engine_config_loader

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int period       = 10,
    parameter int reset_cycles = 4
) (
    output logic ap_clk,
    output logic arst_n
);

    initial begin
        ap_clk = 1'b0;
        forever #(period / 2) ap_clk = ~ap_clk;
    end

    // Release reset away from the active edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge ap_clk);
        @(negedge ap_clk);
        arst_n = 1'b1;
    end

endmodule : tb_clock

// ==== dv/engine_config_loader_tb.sv ====
`timescale 1ns/1ns

module engine_config_loader_tb;

    localparam int engine_slot = 2;
    localparam int win_lo      = engine_slot * cfg_pkg::seq_words;
    localparam int wait_limit  = 2000;

    logic                    ap_clk;
    logic                    arst_n;
    cfg_pkg::mem_word_t      resp_in;
    logic                    resp_prog_full;
    logic                    config_take;
    logic                    config_valid;
    cfg_pkg::engine_config_t config_out;

    cfg_pkg::engine_config_t expected_q[$];
    cfg_pkg::engine_config_t exp_rec;
    logic [31:0]             rng;
    int                      got_count;
    int                      sent_count;
    int                      held_count;

    tb_clock #(.period(10), .reset_cycles(4)) clock0 (.ap_clk(ap_clk), .arst_n(arst_n));

    engine_config_loader #(
        .engine_slot (engine_slot),
        .fifo_depth  (16),
        .prog_thresh (8)
    ) dut0 (
        .ap_clk         (ap_clk),
        .arst_n         (arst_n),
        .resp_in        (resp_in),
        .resp_prog_full (resp_prog_full),
        .config_take    (config_take),
        .config_valid   (config_valid),
        .config_out     (config_out)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected record from eight setup words with word 0 in the low bits
    function automatic cfg_pkg::engine_config_t build_config(input logic [255:0] w);
        cfg_pkg::engine_config_t c;
        c.flags.increment     = w[0];
        c.flags.decrement     = w[1];
        c.flags.mode_sequence = w[2];
        c.flags.mode_buffer   = w[3];
        c.flags.mode_counter  = w[4];
        c.index_start         = w[32 +: 32];
        c.index_end           = w[64 +: 32];
        c.stride              = w[96 +: 32];
        c.granularity         = w[128 +: 31];
        c.direction           = w[159];
        c.array_pointer       = {w[223:192], w[191:160]};
        c.array_size          = w[224 +: 32];
        return c;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            report_failure("Value mismatch");
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge ap_clk);
            resp_in = '0;
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (arst_n !== 1'b1) begin
            @(negedge ap_clk);
            waited++;
            if (waited > wait_limit) report_failure("Timeout: reset never released");
        end
    endtask

    // Holds off while the word buffer reports prog_full
    task automatic send_word(input cfg_pkg::buffer_class_t cls, input int off,
                             input logic [31:0] dat);
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (resp_prog_full) begin
            resp_in = '0;
            waited++;
            if (waited > wait_limit) report_failure("Timeout: resp_prog_full never dropped");
            @(negedge ap_clk);
        end
        resp_in.valid        = 1'b1;
        resp_in.buffer_class = cls;
        resp_in.offset       = cfg_pkg::offset_w'(off);
        resp_in.data         = dat;
    endtask

    task automatic send_sequence(input cfg_pkg::buffer_class_t cls, input logic gaps,
                                 input logic noise);
        logic [255:0] words;
        for (int i = 0; i < 8; i++) begin
            rng = lcg_step(rng);
            words[i*32 +: 32] = rng;
        end
        expected_q.push_back(build_config(words));
        sent_count++;
        for (int i = 0; i < 8; i++) begin
            send_word(cls, win_lo + i, words[i*32 +: 32]);
            // Junk with a wrong class or an offset outside the window
            if (noise) begin
                case (i % 3)
                    0: send_word(cfg_pkg::buf_data, win_lo + i, ~words[i*32 +: 32]);
                    1: send_word(cfg_pkg::buf_none, win_lo, 32'hdead_0000 + i);
                    default: send_word(cfg_pkg::buf_engine_setup, win_lo + 8 + i, rng);
                endcase
                send_word(cfg_pkg::buf_cu_setup, win_lo - 1 - i, 32'h5a5a_0000 + i);
            end
            if (gaps) begin
                rng = lcg_step(rng);
                idle(rng[17:16]);
            end
        end
        idle(1);
    endtask

    task automatic wait_records(input int target);
        int waited;
        waited = 0;
        while (got_count < target) begin
            @(negedge ap_clk);
            waited++;
            if (waited > wait_limit) report_failure("Timeout: expected record never came out");
        end
    endtask

    task automatic wait_back_pressure();
        int waited;
        waited = 0;
        while (!resp_prog_full) begin
            @(negedge ap_clk);
            waited++;
            if (waited > wait_limit) report_failure("Timeout: resp_prog_full never rose");
        end
    endtask

    // ----------------------------------------------------------------------
    // Comparing process
    // ----------------------------------------------------------------------
    // Outputs are stable at the falling edge
    always @(negedge ap_clk) begin
        if (arst_n && config_valid) begin
            if (expected_q.size() == 0) begin
                report_failure("config_valid rose with no record expected");
            end else begin
                exp_rec = expected_q.pop_front();
                compare_value("flags", config_out.flags, exp_rec.flags);
                compare_value("index_start", config_out.index_start, exp_rec.index_start);
                compare_value("index_end", config_out.index_end, exp_rec.index_end);
                compare_value("stride", config_out.stride, exp_rec.stride);
                compare_value("granularity", config_out.granularity, exp_rec.granularity);
                compare_value("direction", config_out.direction, exp_rec.direction);
                compare_value("array_pointer", config_out.array_pointer,
                              exp_rec.array_pointer);
                compare_value("array_size", config_out.array_size, exp_rec.array_size);
                got_count++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        resp_in       = '0;
        config_take   = 1'b0;
        rng           = 32'h3129_ea41;
        got_count     = 0;
        sent_count    = 0;
        held_count    = 0;
        wait_reset_release();
        @(negedge ap_clk);
        compare_value("config_valid", config_valid, 0);
        compare_value("resp_prog_full", resp_prog_full, 0);
        config_take = 1'b1;

        // Single clean sequence
        send_sequence(cfg_pkg::buf_engine_setup, 1'b0, 1'b0);
        wait_records(sent_count);

        // Foreign classes and offsets mixed in
        send_sequence(cfg_pkg::buf_engine_setup, 1'b0, 1'b1);
        wait_records(sent_count);

        // Stray mid-window word ahead of the start word
        send_word(cfg_pkg::buf_engine_setup, win_lo + 3, 32'h0bad_0019);
        idle(2);
        send_sequence(cfg_pkg::buf_engine_setup, 1'b0, 1'b0);
        wait_records(sent_count);

        // Records pile up until the source has to hold off
        config_take = 1'b0;
        held_count  = got_count;
        fork
            repeat (12) send_sequence(cfg_pkg::buf_engine_setup, 1'b0, 1'b0);
            begin
                wait_back_pressure();
                compare_value("records during hold", got_count, held_count);
                config_take = 1'b1;
            end
        join
        wait_records(sent_count);

        // cu_setup with random gaps and a quiet window after
        repeat (3) send_sequence(cfg_pkg::buf_cu_setup, 1'b1, 1'b0);
        wait_records(sent_count);
        repeat (100) begin
            @(negedge ap_clk);
            compare_value("config_valid", config_valid, 0);
        end
        compare_value("pending records", expected_q.size(), 0);
        compare_value("records received", got_count, sent_count);

        $display("All tests passed!");
        $finish;
    end

endmodule : engine_config_loader_tb

// ==== project.f ====
design/cfg_pkg.sv
design/response_filter.sv
design/sync_fifo.sv
design/config_assembler.sv
design/engine_config_loader.sv
dv/tb_clock.sv
dv/engine_config_loader_tb.sv
